//--- src/daq_consts.svh
`ifndef DAQ_CONSTS_SVH
`define DAQ_CONSTS_SVH

// ------------------------------------------------------------------------
// acquisition path sizing
// ------------------------------------------------------------------------
`define ADC_BITS        12      // adc code width
`define CAPTURE_DEPTH   64      // samples per channel per trigger
`define CAP_ADDR_BITS   6       // log2 of capture depth

// ------------------------------------------------------------------------
// host bus
// ------------------------------------------------------------------------
`define WB_ADDR_BITS    8       // word address
`define WB_DATA_BITS    32
`define STATUS_ADDR     8'hFF   // done + count word

`define PULSE_CNT_BITS  11      // width and number settings
`define GAP_CNT_BITS    16      // gap setting, in clock cycles

`endif

//--- src/adc_pkg.sv
`default_nettype none
`include "daq_consts.svh"

package adc_pkg;

    // one registered adc sample, half a buffer word
    typedef struct packed {
        logic                   ovr;    // overrange pin
        logic [2:0]             rsvd;   // always zero
        logic [`ADC_BITS-1:0]   code;
    } adc_sample_t;

    typedef logic [`CAP_ADDR_BITS-1:0] cap_idx_t;  // position in capture

    typedef struct packed {
        adc_sample_t ch1;   // upper half
        adc_sample_t ch0;   // lower half
    } sample_pair_t;

    // buffer word: written as a sample pair, read by the host as raw bits
    typedef union packed {
        sample_pair_t                       pair;
        logic [2*$bits(adc_sample_t)-1:0]   raw;
    } buf_word_u;

endpackage

`default_nettype wire

//--- src/wb_pkg.sv
`default_nettype none
`include "daq_consts.svh"

package wb_pkg;

    typedef logic [`WB_ADDR_BITS-1:0] wb_addr_t;   // word address
    typedef logic [`WB_DATA_BITS-1:0] wb_data_t;

    // status register at STATUS_ADDR
    typedef struct packed {
        logic [`WB_DATA_BITS-9:0]   rsvd;   // reads zero
        logic [6:0]                 count;  // samples in last capture, mod 128
        logic                       done;   // capture complete
    } status_word_t;

    // which block answers a given word address
    typedef enum logic [1:0] {
        MAP_MEM,        // sample memory
        MAP_STATUS,     // status word
        MAP_NONE        // unmapped, reads zero
    } wb_region_e;

endpackage

`default_nettype wire

//--- src/capture_if.sv
`timescale 1ns/1ps
`default_nettype none

// one channel's capture stream, no back-pressure
interface capture_if
    import adc_pkg::*;
();

    logic           valid;      // sample present this cycle
    cap_idx_t       idx;        // buffer slot
    adc_sample_t    sample;
    logic           last;       // final sample of the capture

    modport src (
        output valid,
        output idx,
        output sample,
        output last
    );

    modport dst (
        input  valid,
        input  idx,
        input  sample,
        input  last
    );

endinterface

`default_nettype wire

//--- src/pulse_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "daq_consts.svh"

module pulse_gen (
    input  logic                        i_clk_200m,
    input  logic                        i_rst_n,
    input  logic                        i_start,    // one-cycle request
    input  logic [`PULSE_CNT_BITS-1:0]  i_width,    // high cycles per pulse
    input  logic [`PULSE_CNT_BITS-1:0]  i_num,      // pulses per train
    input  logic [`GAP_CNT_BITS-1:0]    i_gap,      // low cycles after each pulse
    output logic                        o_pulse,
    output logic                        o_trig,     // marks first rising edge
    output logic                        o_done
);

    typedef enum logic [1:0] {ST_IDLE, ST_HIGH, ST_LOW} state_e;

    localparam int PAD = `GAP_CNT_BITS - `PULSE_CNT_BITS;

    state_e                         state;
    logic [`PULSE_CNT_BITS-1:0]     width_q;        // latched at start
    logic [`GAP_CNT_BITS-1:0]       gap_q;
    logic [`GAP_CNT_BITS-1:0]       phase_cnt;      // cycles left in this phase
    logic [`PULSE_CNT_BITS-1:0]     pulse_left;     // pulses left incl. current
    logic                           start_ok;
    logic                           phase_end;
    logic                           train_end;

    assign start_ok  = (i_width != '0) && (i_num != '0);   // else no train at all
    assign phase_end = (phase_cnt == 1);
    assign train_end = (pulse_left == 1);

    // settings held for the whole train
    always_ff @(posedge i_clk_200m) begin
        if (state == ST_IDLE && i_start) begin
            width_q <= i_width;
            gap_q   <= i_gap;
        end
    end

    // ------------------------------------------------------------------------
    // high / low phase sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk_200m) begin
        if (!i_rst_n) begin
            state      <= ST_IDLE;
            phase_cnt  <= '0;
            pulse_left <= '0;
            o_pulse    <= 1'b0;
            o_trig     <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            o_trig <= 1'b0;                     // single cycle only
            case (state)
                ST_IDLE: begin
                    if (i_start && start_ok) begin
                        state      <= ST_HIGH;
                        o_pulse    <= 1'b1;     // high from cycle 1
                        o_trig     <= 1'b1;
                        o_done     <= 1'b0;
                        phase_cnt  <= {{PAD{1'b0}}, i_width};
                        pulse_left <= i_num;
                    end else if (i_start) begin
                        o_done <= 1'b1;         // empty train, done at once
                    end
                end
                ST_HIGH: begin
                    if (!phase_end) begin
                        phase_cnt <= phase_cnt - 1'b1;
                    end else if (gap_q != '0) begin
                        state     <= ST_LOW;
                        o_pulse   <= 1'b0;
                        phase_cnt <= gap_q;
                    end else if (train_end) begin
                        state   <= ST_IDLE;     // zero gap, last pulse
                        o_pulse <= 1'b0;
                        o_done  <= 1'b1;
                    end else begin
                        pulse_left <= pulse_left - 1'b1;    // back-to-back pulse
                        phase_cnt  <= {{PAD{1'b0}}, width_q};
                    end
                end
                ST_LOW: begin
                    if (!phase_end) begin
                        phase_cnt <= phase_cnt - 1'b1;
                    end else if (train_end) begin
                        state  <= ST_IDLE;
                        o_done <= 1'b1;         // cycle after last gap
                    end else begin
                        state      <= ST_HIGH;
                        o_pulse    <= 1'b1;
                        pulse_left <= pulse_left - 1'b1;
                        phase_cnt  <= {{PAD{1'b0}}, width_q};
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/adc_capture.sv
`timescale 1ns/1ps
`default_nettype none
`include "daq_consts.svh"

module adc_capture
    import adc_pkg::*;
(
    input  logic                    i_clk_200m,
    input  logic                    i_rst_n,
    input  logic                    i_trig,     // from pulse_gen
    input  logic [`ADC_BITS-1:0]    i_code,     // deserialised adc bus
    input  logic                    i_or,       // overrange
    capture_if.src                  cap
);

    localparam cap_idx_t LAST_IDX = cap_idx_t'(`CAPTURE_DEPTH - 1);

    adc_sample_t    sample_d;
    adc_sample_t    sample_q;   // pin register, one cycle behind pins
    logic           busy;       // streaming a capture
    cap_idx_t       idx_q;

    // ------------------------------------------------------------------------
    // input register
    // ------------------------------------------------------------------------
    always_comb begin
        sample_d      = '0;
        sample_d.ovr  = i_or;
        sample_d.rsvd = 3'b000;
        sample_d.code = i_code;
    end

    always_ff @(posedge i_clk_200m) begin
        sample_q <= sample_d;   // free running
    end

    // ------------------------------------------------------------------------
    // capture sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk_200m) begin
        if (!i_rst_n) begin
            busy  <= 1'b0;
            idx_q <= '0;
        end else if (!busy) begin
            if (i_trig) begin
                busy  <= 1'b1;          // trigger-cycle sample is index 0
                idx_q <= '0;
            end
        end else if (idx_q == LAST_IDX) begin
            busy  <= 1'b0;              // retrigger ignored until here
            idx_q <= '0;
        end else begin
            idx_q <= idx_q + 1'b1;
        end
    end

    assign cap.valid  = busy;
    assign cap.idx    = idx_q;
    assign cap.sample = sample_q;
    assign cap.last   = busy && (idx_q == LAST_IDX);

endmodule

`default_nettype wire

//--- src/capture_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "daq_consts.svh"

module capture_buffer
    import adc_pkg::*;
    import wb_pkg::*;
(
    input  logic        i_clk_200m,
    input  logic        i_rst_n,
    capture_if.dst      cap0,       // lower half of each word
    capture_if.dst      cap1,       // upper half
    input  logic        i_wb_cyc,
    input  logic        i_wb_stb,
    input  logic        i_wb_we,
    input  wb_addr_t    i_wb_adr,
    output wb_data_t    o_wb_dat,
    output logic        o_wb_ack
);

    localparam logic [6:0] FULL_COUNT = 7'(`CAPTURE_DEPTH % 128);

    buf_word_u      mem [`CAPTURE_DEPTH];   // sample memory
    buf_word_u      wr_word;
    logic           wr_en;
    logic           wr_last;
    logic           done_q;
    logic [6:0]     count_q;
    status_word_t   status;
    wb_region_e     region;
    cap_idx_t       rd_idx;
    wb_data_t       rd_data;
    logic           wb_req;

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------
    assign wr_en   = cap0.valid && cap1.valid && (cap0.idx == cap1.idx);  // channels in step
    assign wr_last = cap0.last && cap1.last;

    always_comb begin
        wr_word          = '0;
        wr_word.pair.ch0 = cap0.sample;
        wr_word.pair.ch1 = cap1.sample;
    end

    always_ff @(posedge i_clk_200m) begin
        if (wr_en) begin
            mem[cap0.idx] <= wr_word;   // readable next cycle
        end
    end

    // done / count tracking
    always_ff @(posedge i_clk_200m) begin
        if (!i_rst_n) begin
            done_q  <= 1'b0;
            count_q <= '0;
        end else if (wr_en) begin
            if (cap0.idx == '0) begin
                done_q  <= 1'b0;        // new capture started
                count_q <= '0;
            end
            if (wr_last) begin
                done_q  <= 1'b1;
                count_q <= FULL_COUNT;
            end
        end
    end

    always_comb begin
        status       = '0;
        status.done  = done_q;
        status.count = count_q;
    end

    // ------------------------------------------------------------------------
    // wishbone classic slave, read-only data
    // ------------------------------------------------------------------------
    assign rd_idx = i_wb_adr[`CAP_ADDR_BITS-1:0];
    assign wb_req = i_wb_cyc && i_wb_stb && !o_wb_ack;  // new request

    always_comb begin
        if (i_wb_adr < `CAPTURE_DEPTH)
            region = MAP_MEM;
        else if (i_wb_adr == `STATUS_ADDR)
            region = MAP_STATUS;
        else
            region = MAP_NONE;
    end

    always_comb begin
        case (region)
            MAP_MEM:    rd_data = mem[rd_idx].raw;
            MAP_STATUS: rd_data = status;
            default:    rd_data = '0;
        endcase
        if (i_wb_we)
            rd_data = '0;               // writes acked, nothing stored
    end

    always_ff @(posedge i_clk_200m) begin
        if (!i_rst_n)
            o_wb_ack <= 1'b0;
        else
            o_wb_ack <= wb_req;         // one cycle, next clock
    end

    always_ff @(posedge i_clk_200m) begin
        if (wb_req)
            o_wb_dat <= rd_data;        // lands with ack
    end

endmodule

`default_nettype wire

//--- src/daq_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "daq_consts.svh"

module daq_top
    import wb_pkg::*;
(
    input  logic                        i_clk_200m,
    input  logic                        i_rst_n,

    // pulse train settings
    input  logic                        i_start,
    input  logic [`PULSE_CNT_BITS-1:0]  i_width,
    input  logic [`PULSE_CNT_BITS-1:0]  i_num,
    input  logic [`GAP_CNT_BITS-1:0]    i_gap,

    // adc0
    input  logic [`ADC_BITS-1:0]        i_adc0_code,
    input  logic                        i_adc0_or,
    // adc1
    input  logic [`ADC_BITS-1:0]        i_adc1_code,
    input  logic                        i_adc1_or,

    output logic                        o_pulse,
    output logic                        o_trig,
    output logic                        o_done,

    // wishbone slave
    input  logic                        i_wb_cyc,
    input  logic                        i_wb_stb,
    input  logic                        i_wb_we,
    input  wb_addr_t                    i_wb_adr,
    output wb_data_t                    o_wb_dat,
    output logic                        o_wb_ack
);

    logic pulse_trig;   // shared by both channels

    capture_if cap0 ();
    capture_if cap1 ();

    // ------------------------------------------------------------------------
    // pulse generator
    // ------------------------------------------------------------------------
    pulse_gen pulse_gen_inst (
        .i_clk_200m (i_clk_200m),
        .i_rst_n    (i_rst_n),
        .i_start    (i_start),
        .i_width    (i_width),
        .i_num      (i_num),
        .i_gap      (i_gap),
        .o_pulse    (o_pulse),
        .o_trig     (pulse_trig),
        .o_done     (o_done)
    );

    assign o_trig = pulse_trig;

    // ------------------------------------------------------------------------
    // adc channels
    // ------------------------------------------------------------------------
    adc_capture adc_capture_0 (
        .i_clk_200m (i_clk_200m),
        .i_rst_n    (i_rst_n),
        .i_trig     (pulse_trig),
        .i_code     (i_adc0_code),
        .i_or       (i_adc0_or),
        .cap        (cap0.src)
    );

    adc_capture adc_capture_1 (
        .i_clk_200m (i_clk_200m),
        .i_rst_n    (i_rst_n),
        .i_trig     (pulse_trig),
        .i_code     (i_adc1_code),
        .i_or       (i_adc1_or),
        .cap        (cap1.src)
    );

    // sample memory + host port
    capture_buffer capture_buffer_inst (
        .i_clk_200m (i_clk_200m),
        .i_rst_n    (i_rst_n),
        .cap0       (cap0.dst),
        .cap1       (cap1.dst),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_adr   (i_wb_adr),
        .o_wb_dat   (o_wb_dat),
        .o_wb_ack   (o_wb_ack)
    );

endmodule

`default_nettype wire

//--- tests/tb_daq_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "daq_consts.svh"

module tb_daq_top
    import adc_pkg::*;
    import wb_pkg::*;
();

    typedef struct packed {
        logic                   or1;
        logic [`ADC_BITS-1:0]   code1;
        logic                   or0;
        logic [`ADC_BITS-1:0]   code0;
    } pins_t;                                   // both adcs in one cycle

    logic                       clk_200m = 1'b0;
    logic                       rst_n;
    logic                       start;
    logic [`PULSE_CNT_BITS-1:0] width;
    logic [`PULSE_CNT_BITS-1:0] num;
    logic [`GAP_CNT_BITS-1:0]   gap;
    logic [`ADC_BITS-1:0]       adc0_code;
    logic                       adc0_or;
    logic [`ADC_BITS-1:0]       adc1_code;
    logic                       adc1_or;
    logic                       pulse;
    logic                       trig;
    logic                       done;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    wb_addr_t                   wb_adr;
    wb_data_t                   wb_dat;
    logic                       wb_ack;

    int         cyc_cnt = 0;            // rising edges so far
    pins_t      hist [int];             // pin levels by cycle
    int         trig_cyc = 0;           // cycle T of the last trigger
    int         trig_cnt = 0;
    logic       settings_ready = 1'b0;
    int         r_width;                // random train of the second run
    int         r_gap;
    int         r_num;
    int         z_width;                // empty train with num 0
    int         z_gap;
    int         j_width;                // settings sent while busy
    int         j_gap;
    int         j_num;

    logic       mdl_busy = 1'b0;        // pulse train reference
    logic       mdl_done = 1'b0;
    int         mdl_k = 0;              // 1 = trigger cycle
    int         mdl_w = 0;
    int         mdl_g = 0;
    int         mdl_total = 0;
    logic       exp_pulse;
    logic       exp_trig;

    daq_top uut (
        .i_clk_200m (clk_200m),
        .i_rst_n    (rst_n),
        .i_start    (start),
        .i_width    (width),
        .i_num      (num),
        .i_gap      (gap),
        .i_adc0_code(adc0_code),
        .i_adc0_or  (adc0_or),
        .i_adc1_code(adc1_code),
        .i_adc1_or  (adc1_or),
        .o_pulse    (pulse),
        .o_trig     (trig),
        .o_done     (done),
        .i_wb_cyc   (wb_cyc),
        .i_wb_stb   (wb_stb),
        .i_wb_we    (wb_we),
        .i_wb_adr   (wb_adr),
        .o_wb_dat   (wb_dat),
        .o_wb_ack   (wb_ack)
    );

    always #50 clk_200m = ~clk_200m;    // 100 ns period

    always @(posedge clk_200m) cyc_cnt <= cyc_cnt + 1;

    // ------------------------------------------------------------------------
    // reporting and reference
    // ------------------------------------------------------------------------
    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input buf_word_u exp, input buf_word_u act);
        if (act.raw !== exp.raw) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp.raw, act.raw);
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input status_word_t exp,
                                input status_word_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    // word at idx holds the pins of cycle T+idx with ch1 in the high half
    function automatic buf_word_u ref_word(input int idx);
        pins_t      p;
        buf_word_u  w;
        p = hist[trig_cyc + idx];
        w = '0;
        w.pair.ch0.ovr  = p.or0;
        w.pair.ch0.code = p.code0;
        w.pair.ch1.ovr  = p.or1;
        w.pair.ch1.code = p.code1;
        return w;
    endfunction

    function automatic status_word_t ref_status(input logic d, input int cnt);
        status_word_t s;
        s = '0;
        s.done  = d;
        s.count = 7'(cnt % 128);
        return s;
    endfunction

    // ------------------------------------------------------------------------
    // pulse_gen compare at mid cycle where outputs are settled
    // ------------------------------------------------------------------------
    always @(negedge clk_200m) begin : pulse_model
        pins_t p;
        if (rst_n) begin
            exp_pulse = 1'b0;
            exp_trig  = 1'b0;
            if (mdl_busy) begin
                exp_pulse = ((mdl_k - 1) % (mdl_w + mdl_g)) < mdl_w;   // high phase first
                exp_trig  = (mdl_k == 1);
            end
            check_bit("o_pulse", exp_pulse, pulse);
            check_bit("o_trig", exp_trig, trig);
            check_bit("o_done", mdl_done, done);
            if (trig) begin
                trig_cyc = cyc_cnt;
                trig_cnt = trig_cnt + 1;
            end
        end
        p.or0   = adc0_or;
        p.code0 = adc0_code;
        p.or1   = adc1_or;
        p.code1 = adc1_code;
        hist[cyc_cnt] = p;
        // next-cycle state from this cycle's inputs
        if (!rst_n) begin
            mdl_busy = 1'b0;
            mdl_done = 1'b0;
        end else if (mdl_busy) begin
            if (mdl_k == mdl_total) begin
                mdl_busy = 1'b0;                // last gap over
                mdl_done = 1'b1;
            end else begin
                mdl_k = mdl_k + 1;
            end
        end else if (start) begin
            if (width != '0 && num != '0) begin
                mdl_busy  = 1'b1;
                mdl_done  = 1'b0;
                mdl_k     = 1;
                mdl_w     = int'(width);
                mdl_g     = int'(gap);
                mdl_total = int'(num) * (mdl_w + mdl_g);
            end else begin
                mdl_done = 1'b1;                // empty train
            end
        end
    end

    // ------------------------------------------------------------------------
    // random settings first and then adc pins every cycle
    // ------------------------------------------------------------------------
    initial begin : random_source
        void'($urandom(32'hb368_558a));
        r_width    = 2 + int'($urandom % 8);
        r_gap      = int'($urandom % 8);        // 0 gives back-to-back pulses
        r_num      = 1 + int'($urandom % 6);
        z_width    = 1 + int'($urandom % 8);
        z_gap      = int'($urandom % 8);
        j_width    = 1 + int'($urandom % 20);
        j_gap      = 1 + int'($urandom % 20);
        j_num      = 1 + int'($urandom % 20);
        adc0_code  = '0;
        adc0_or    = 1'b0;
        adc1_code  = '0;
        adc1_or    = 1'b0;
        settings_ready = 1'b1;
        forever begin
            @(posedge clk_200m);
            #1;
            adc0_code = `ADC_BITS'($urandom);
            adc0_or   = 1'($urandom);
            adc1_code = `ADC_BITS'($urandom);
            adc1_or   = 1'($urandom);
        end
    end

    initial begin : watchdog
        int limit;
        wait (settings_ready);
        limit = 2 * (3 + 3 + 4 * (3 + 5) + r_num * (r_width + r_gap) + 1 + 16
                     + 2 * (`CAPTURE_DEPTH + 2) + 3 * (4 * `CAPTURE_DEPTH + 16));
        repeat (limit) @(posedge clk_200m);
        $display("ERROR: watchdog expired after %0d cycles, test did not finish", limit);
        abort_run();
    end

    // ------------------------------------------------------------------------
    // stimulus helpers run 1 ns after a rising edge
    // ------------------------------------------------------------------------
    task automatic step_cycle();
        @(posedge clk_200m);
        #1;
    endtask

    task automatic start_train(input int w, input int g, input int n);
        width = `PULSE_CNT_BITS'(w);
        gap   = `GAP_CNT_BITS'(g);
        num   = `PULSE_CNT_BITS'(n);
        start = 1'b1;
        step_cycle();
        start = 1'b0;                           // now in cycle 1
    endtask

    task automatic bus_access(input logic we, input wb_addr_t adr, output wb_data_t data);
        int waits;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr;
        waits  = 0;
        do begin
            step_cycle();
            waits++;
        end while (!wb_ack && waits < 2);
        if (!wb_ack) begin
            $display("ERROR: no ack within 2 cycles for access at address 0x%h", adr);
            abort_run();
        end
        if (waits != 1) begin
            $display("ERROR: ack came %0d cycles after the request instead of 1", waits);
            abort_run();
        end
        data   = wb_dat;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        step_cycle();
        check_bit("o_wb_ack", 1'b0, wb_ack);    // ack lasts one cycle
    endtask

    task automatic expect_status(input logic d, input int cnt);
        wb_data_t rd;
        bus_access(1'b0, `STATUS_ADDR, rd);
        check_status("status", ref_status(d, cnt), status_word_t'(rd));
    endtask

    task automatic read_all_samples();
        wb_data_t   rd;
        buf_word_u  act;
        for (int i = 0; i < `CAPTURE_DEPTH; i++) begin
            bus_access(1'b0, wb_addr_t'(i), rd);
            act.raw = rd;
            check_word($sformatf("buffer[%0d]", i), ref_word(i), act);
        end
    endtask

    task automatic expect_trig_count(input int n);
        if (trig_cnt != n) begin
            $display("ERROR: saw %0d triggers, expected %0d", trig_cnt, n);
            abort_run();
        end
    endtask

    task automatic wait_capture_done();
        while (!done)
            step_cycle();
        while (cyc_cnt < trig_cyc + `CAPTURE_DEPTH + 1)    // last sample readable
            step_cycle();
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin : stimulus
        wb_data_t   rd;
        buf_word_u  act;
        int         sent;
        rst_n  = 1'b0;
        start  = 1'b0;
        width  = '0;
        num    = '0;
        gap    = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        wb_adr = '0;
        repeat (3) step_cycle();
        rst_n = 1'b1;
        wait (settings_ready);

        check_bit("o_pulse", 1'b0, pulse);      // reset values
        check_bit("o_trig", 1'b0, trig);
        check_bit("o_done", 1'b0, done);
        check_bit("o_wb_ack", 1'b0, wb_ack);
        expect_status(1'b0, 0);

        start_train(0, 5, 4);                   // zero width raises done only
        repeat (2) step_cycle();
        expect_trig_count(0);

        start_train(3, 5, 4);                   // fixed train
        wait_capture_done();
        expect_trig_count(1);
        read_all_samples();
        expect_status(1'b1, `CAPTURE_DEPTH);

        bus_access(1'b1, 8'h00, rd);            // writes are acked and ignored
        bus_access(1'b1, 8'h05, rd);
        bus_access(1'b1, `STATUS_ADDR, rd);
        bus_access(1'b1, 8'h80, rd);
        expect_status(1'b1, `CAPTURE_DEPTH);
        bus_access(1'b0, 8'h80, rd);            // unmapped
        act.raw = rd;
        check_word("unmapped read", '0, act);
        read_all_samples();

        start_train(r_width, r_gap, r_num);     // random train
        sent = 0;
        while (mdl_busy && sent < 2) begin
            width = `PULSE_CNT_BITS'(j_width);  // must not be taken
            gap   = `GAP_CNT_BITS'(j_gap);
            num   = `PULSE_CNT_BITS'(j_num);
            start = 1'b1;
            step_cycle();
            start = 1'b0;
            step_cycle();
            sent++;
        end
        wait_capture_done();
        expect_trig_count(2);
        read_all_samples();
        expect_status(1'b1, `CAPTURE_DEPTH);

        start_train(z_width, z_gap, 0);         // no pulse and no trigger
        repeat (4) step_cycle();
        expect_trig_count(2);
        expect_status(1'b1, `CAPTURE_DEPTH);
        read_all_samples();                     // still the second capture

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- daq_capture.f
+incdir+src
src/adc_pkg.sv
src/wb_pkg.sv
src/capture_if.sv
src/pulse_gen.sv
src/adc_capture.sv
src/capture_buffer.sv
src/daq_top.sv
tests/tb_daq_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench, exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_daq_top -f daq_capture.f -o tb_daq_top
./obj_dir/tb_daq_top
